// File: design/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // ========================================================================
    // Datapath widths
    // ========================================================================

    // Architectural data word
    localparam int xlen = 32;
    // Physical register tag
    localparam int preg_bits = 6;
    // Reorder buffer index
    localparam int rob_bits = 5;
    // Next PC step for link-style operand A
    localparam int inst_bytes = 4;

    // ========================================================================
    // ALU function codes
    // ========================================================================

    localparam int func_bits = 4;

    localparam logic [func_bits-1:0] alu_add  = 4'h0;
    localparam logic [func_bits-1:0] alu_sub  = 4'h1;
    localparam logic [func_bits-1:0] alu_and  = 4'h2;
    localparam logic [func_bits-1:0] alu_or   = 4'h3;
    localparam logic [func_bits-1:0] alu_xor  = 4'h4;
    localparam logic [func_bits-1:0] alu_slt  = 4'h5;
    localparam logic [func_bits-1:0] alu_sltu = 4'h6;
    localparam logic [func_bits-1:0] alu_sll  = 4'h7;
    localparam logic [func_bits-1:0] alu_srl  = 4'h8;
    localparam logic [func_bits-1:0] alu_sra  = 4'h9;

    // ========================================================================
    // Operand select codes
    // ========================================================================

    // Operand A, fully decoded over two bits
    localparam int opa_bits = 2;

    localparam logic [opa_bits-1:0] opa_rs1  = 2'd0;
    localparam logic [opa_bits-1:0] opa_npc  = 2'd1;
    localparam logic [opa_bits-1:0] opa_pc   = 2'd2;
    localparam logic [opa_bits-1:0] opa_zero = 2'd3;

    // Operand B, register or stored immediate
    localparam int opb_bits = 1;

    localparam logic [opb_bits-1:0] opb_rs2 = 1'b0;
    localparam logic [opb_bits-1:0] opb_imm = 1'b1;

endpackage

`default_nettype wire

// File: design/alu_op_if.sv
`default_nettype none

interface alu_op_if;

    import exec_pkg::*;

    // Lane occupied this cycle
    logic                 valid;
    // ALU function code
    logic [func_bits-1:0] func;
    // Resolved operands
    logic [xlen-1:0]      opa;
    logic [xlen-1:0]      opb;
    // Bookkeeping carried to completion
    logic [preg_bits-1:0] dest_tag;
    logic [rob_bits-1:0]  rob_idx;

    // Operand stage side
    modport src (
        output valid, func, opa, opb, dest_tag, rob_idx
    );

    // ALU lane side
    modport sink (
        input valid, func, opa, opb, dest_tag, rob_idx
    );

endinterface

`default_nettype wire

// File: design/alu_result_if.sv
`default_nettype none

interface alu_result_if;

    import exec_pkg::*;

    // Result qualifier, same level as the issue valid
    logic                 valid;
    logic [xlen-1:0]      result;
    logic [preg_bits-1:0] dest_tag;
    logic [rob_bits-1:0]  rob_idx;

    // ALU lane side
    modport src (
        output valid, result, dest_tag, rob_idx
    );

    // Completion side
    modport sink (
        input valid, result, dest_tag, rob_idx
    );

endinterface

`default_nettype wire

// File: design/operand_resolve.sv
`default_nettype none

module operand_resolve #(
    parameter int num_alu   = 3,
    parameter int cdb_width = 2
) (
    // Issue lanes
    input  logic [num_alu-1:0]                          issue_valid,
    input  logic [num_alu-1:0][exec_pkg::func_bits-1:0] issue_func,
    input  logic [num_alu-1:0][exec_pkg::opa_bits-1:0]  issue_opa_sel,
    input  logic [num_alu-1:0][exec_pkg::opb_bits-1:0]  issue_opb_sel,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]      issue_pc,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]      issue_imm,
    input  logic [num_alu-1:0][exec_pkg::preg_bits-1:0] issue_src1_tag,
    input  logic [num_alu-1:0][exec_pkg::preg_bits-1:0] issue_src2_tag,
    input  logic [num_alu-1:0][exec_pkg::preg_bits-1:0] issue_dest_tag,
    input  logic [num_alu-1:0][exec_pkg::rob_bits-1:0]  issue_rob_idx,

    // PRF read ports, answered in the same cycle
    output logic [num_alu-1:0]                          prf_rd_en1,
    output logic [num_alu-1:0]                          prf_rd_en2,
    output logic [num_alu-1:0][exec_pkg::preg_bits-1:0] prf_rd_tag1,
    output logic [num_alu-1:0][exec_pkg::preg_bits-1:0] prf_rd_tag2,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]      prf_rd_data1,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]      prf_rd_data2,

    // CDB broadcast for forwarding
    input  logic [cdb_width-1:0]                          cdb_valid,
    input  logic [cdb_width-1:0][exec_pkg::preg_bits-1:0] cdb_tag,
    input  logic [cdb_width-1:0][exec_pkg::xlen-1:0]      cdb_data,

    // Resolved operations, one per lane
    alu_op_if.src op [num_alu-1:0]
);

    import exec_pkg::*;

    // Source values after forwarding
    logic [num_alu-1:0][xlen-1:0] src1_val;
    logic [num_alu-1:0][xlen-1:0] src2_val;
    // Selected operands
    logic [num_alu-1:0][xlen-1:0] opa_val;
    logic [num_alu-1:0][xlen-1:0] opb_val;

    // ========================================================================
    // PRF read requests
    // ========================================================================

    always_comb begin
        for (int i = 0; i < num_alu; i++) begin
            // RS1 always read for a live lane
            prf_rd_en1[i]  = issue_valid[i];
            // RS2 only when operand B is a register
            prf_rd_en2[i]  = issue_valid[i] && (issue_opb_sel[i] == opb_rs2);
            // Idle lanes present zero tags
            prf_rd_tag1[i] = issue_valid[i] ? issue_src1_tag[i] : '0;
            prf_rd_tag2[i] = issue_valid[i] ? issue_src2_tag[i] : '0;
        end
    end

    // ========================================================================
    // CDB forwarding
    // ========================================================================

    always_comb begin
        for (int i = 0; i < num_alu; i++) begin
            // PRF value may be stale by one broadcast
            src1_val[i] = prf_rd_data1[i];
            src2_val[i] = prf_rd_data2[i];
            // Ascending scan, so the highest matching slot wins
            for (int c = 0; c < cdb_width; c++) begin
                if (cdb_valid[c] && (cdb_tag[c] == issue_src1_tag[i])) begin
                    src1_val[i] = cdb_data[c];
                end
                if (cdb_valid[c] && (cdb_tag[c] == issue_src2_tag[i])) begin
                    src2_val[i] = cdb_data[c];
                end
            end
        end
    end

    // ========================================================================
    // Operand selection
    // ========================================================================

    always_comb begin
        for (int i = 0; i < num_alu; i++) begin
            case (issue_opa_sel[i])
                opa_rs1: opa_val[i] = src1_val[i];
                opa_npc: opa_val[i] = issue_pc[i] + xlen'(inst_bytes);
                opa_pc:  opa_val[i] = issue_pc[i];
                default: opa_val[i] = '0;
            endcase
            // All immediate kinds share one stored value
            opb_val[i] = (issue_opb_sel[i] == opb_imm) ? issue_imm[i] : src2_val[i];
        end
    end

    // Drive each lane's operation bundle
    for (genvar g = 0; g < num_alu; g++) begin : g_lane
        assign op[g].valid    = issue_valid[g];
        assign op[g].func     = issue_func[g];
        assign op[g].opa      = opa_val[g];
        assign op[g].opb      = opb_val[g];
        assign op[g].dest_tag = issue_dest_tag[g];
        assign op[g].rob_idx  = issue_rob_idx[g];
    end

endmodule

`default_nettype wire

// File: design/alu_lane.sv
`default_nettype none

module alu_lane (
    alu_op_if.sink    op,
    alu_result_if.src res
);

    import exec_pkg::*;

    // Shift amount, RV32 uses five bits
    logic [4:0] shamt;
    // Compare outcomes
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = op.opb[4:0];
    assign lt_signed   = $signed(op.opa) < $signed(op.opb);
    assign lt_unsigned = op.opa < op.opb;

    // ========================================================================
    // Function decode
    // ========================================================================

    always_comb begin
        case (op.func)
            alu_add:  res.result = op.opa + op.opb;
            alu_sub:  res.result = op.opa - op.opb;
            alu_and:  res.result = op.opa & op.opb;
            alu_or:   res.result = op.opa | op.opb;
            alu_xor:  res.result = op.opa ^ op.opb;
            // Set-less-than gives a zero-extended flag
            alu_slt:  res.result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: res.result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_sll:  res.result = op.opa << shamt;
            alu_srl:  res.result = op.opa >> shamt;
            // Arithmetic shift keeps the sign bit
            alu_sra:  res.result = $unsigned($signed(op.opa) >>> shamt);
            // Unused codes
            default:  res.result = '0;
        endcase
    end

    // ========================================================================
    // Bookkeeping pass-through
    // ========================================================================

    // Single cycle, so the issue metadata is still current
    assign res.valid    = op.valid;
    assign res.dest_tag = op.dest_tag;
    assign res.rob_idx  = op.rob_idx;

endmodule

`default_nettype wire

// File: design/completion_select.sv
`default_nettype none

module completion_select #(
    parameter int num_alu   = 3,
    parameter int cdb_width = 2
) (
    input  logic clock,
    input  logic rst_n,
    input  logic mispredict,

    // Per slot, one grant bit per lane
    input  logic [cdb_width-1:0][num_alu-1:0] gnt,

    // Lane results
    alu_result_if.sink res [num_alu-1:0],

    // CDB candidates
    output logic [num_alu-1:0]                          fu_valid,
    output logic [num_alu-1:0][exec_pkg::preg_bits-1:0] fu_tag,
    output logic [num_alu-1:0][exec_pkg::xlen-1:0]      fu_data,

    // EX/COMP register
    output logic [cdb_width-1:0]                          ex_valid,
    output logic [cdb_width-1:0][exec_pkg::rob_bits-1:0]  ex_rob_idx,
    output logic [cdb_width-1:0][exec_pkg::preg_bits-1:0] ex_dest_pr,
    output logic [cdb_width-1:0][exec_pkg::xlen-1:0]      ex_result
);

    import exec_pkg::*;

    // Lane rob indices, flattened for indexed access
    logic [num_alu-1:0][rob_bits-1:0] lane_rob;

    // Per-slot selection before the register
    logic [cdb_width-1:0]                sel_valid;
    logic [cdb_width-1:0][rob_bits-1:0]  sel_rob;
    logic [cdb_width-1:0][preg_bits-1:0] sel_dest;
    logic [cdb_width-1:0][xlen-1:0]      sel_result;

    // ========================================================================
    // CDB candidates
    // ========================================================================

    for (genvar g = 0; g < num_alu; g++) begin : g_lane
        assign fu_valid[g] = res[g].valid;
        assign fu_tag[g]   = res[g].dest_tag;
        assign fu_data[g]  = res[g].result;
        assign lane_rob[g] = res[g].rob_idx;
    end

    // ========================================================================
    // Grant selection
    // ========================================================================

    always_comb begin
        for (int i = 0; i < cdb_width; i++) begin
            sel_valid[i]  = 1'b0;
            sel_rob[i]    = '0;
            sel_dest[i]   = '0;
            sel_result[i] = '0;
            // Later lanes override, highest grant wins
            for (int k = 0; k < num_alu; k++) begin
                if (gnt[i][k]) begin
                    sel_valid[i]  = 1'b1;
                    sel_rob[i]    = lane_rob[k];
                    sel_dest[i]   = fu_tag[k];
                    sel_result[i] = fu_data[k];
                end
            end
        end
    end

    // ========================================================================
    // EX/COMP register
    // ========================================================================

    // Valids flushed on mispredict
    always_ff @(posedge clock) begin
        if (!rst_n || mispredict) begin
            ex_valid <= '0;
        end else begin
            ex_valid <= sel_valid;
        end
    end

    // Payload only meaningful under ex_valid
    always_ff @(posedge clock) begin
        ex_rob_idx <= sel_rob;
        ex_dest_pr <= sel_dest;
        ex_result  <= sel_result;
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`default_nettype none

module execute_stage #(
    parameter int num_alu   = 3,
    parameter int cdb_width = 2
) (
    input  logic clock,
    input  logic rst_n,

    // Issue lanes
    input  logic [num_alu-1:0]                          issue_valid,
    input  logic [num_alu-1:0][exec_pkg::func_bits-1:0] issue_func,
    input  logic [num_alu-1:0][exec_pkg::opa_bits-1:0]  issue_opa_sel,
    input  logic [num_alu-1:0][exec_pkg::opb_bits-1:0]  issue_opb_sel,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]      issue_pc,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]      issue_imm,
    input  logic [num_alu-1:0][exec_pkg::preg_bits-1:0] issue_src1_tag,
    input  logic [num_alu-1:0][exec_pkg::preg_bits-1:0] issue_src2_tag,
    input  logic [num_alu-1:0][exec_pkg::preg_bits-1:0] issue_dest_tag,
    input  logic [num_alu-1:0][exec_pkg::rob_bits-1:0]  issue_rob_idx,

    // PRF reads
    output logic [num_alu-1:0]                          prf_rd_en1,
    output logic [num_alu-1:0]                          prf_rd_en2,
    output logic [num_alu-1:0][exec_pkg::preg_bits-1:0] prf_rd_tag1,
    output logic [num_alu-1:0][exec_pkg::preg_bits-1:0] prf_rd_tag2,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]      prf_rd_data1,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]      prf_rd_data2,

    // CDB broadcast
    input  logic [cdb_width-1:0]                          cdb_valid,
    input  logic [cdb_width-1:0][exec_pkg::preg_bits-1:0] cdb_tag,
    input  logic [cdb_width-1:0][exec_pkg::xlen-1:0]      cdb_data,

    // CDB arbitration and flush
    input  logic [cdb_width-1:0][num_alu-1:0] gnt,
    input  logic                              mispredict,

    // CDB candidates
    output logic [num_alu-1:0]                          fu_valid,
    output logic [num_alu-1:0][exec_pkg::preg_bits-1:0] fu_tag,
    output logic [num_alu-1:0][exec_pkg::xlen-1:0]      fu_data,

    // EX/COMP register
    output logic [cdb_width-1:0]                          ex_valid,
    output logic [cdb_width-1:0][exec_pkg::rob_bits-1:0]  ex_rob_idx,
    output logic [cdb_width-1:0][exec_pkg::preg_bits-1:0] ex_dest_pr,
    output logic [cdb_width-1:0][exec_pkg::xlen-1:0]      ex_result
);

    // Operand stage to lanes
    alu_op_if     op_if  [num_alu-1:0] ();
    // Lanes to completion
    alu_result_if res_if [num_alu-1:0] ();

    // ========================================================================
    // Operand stage
    // ========================================================================

    operand_resolve #(
        .num_alu   (num_alu),
        .cdb_width (cdb_width)
    ) u_operand_resolve (
        .issue_valid    (issue_valid),
        .issue_func     (issue_func),
        .issue_opa_sel  (issue_opa_sel),
        .issue_opb_sel  (issue_opb_sel),
        .issue_pc       (issue_pc),
        .issue_imm      (issue_imm),
        .issue_src1_tag (issue_src1_tag),
        .issue_src2_tag (issue_src2_tag),
        .issue_dest_tag (issue_dest_tag),
        .issue_rob_idx  (issue_rob_idx),
        .prf_rd_en1     (prf_rd_en1),
        .prf_rd_en2     (prf_rd_en2),
        .prf_rd_tag1    (prf_rd_tag1),
        .prf_rd_tag2    (prf_rd_tag2),
        .prf_rd_data1   (prf_rd_data1),
        .prf_rd_data2   (prf_rd_data2),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .op             (op_if)
    );

    // ========================================================================
    // ALU lanes
    // ========================================================================

    for (genvar g = 0; g < num_alu; g++) begin : g_alu
        alu_lane u_alu_lane (
            .op  (op_if[g]),
            .res (res_if[g])
        );
    end

    // ========================================================================
    // Completion
    // ========================================================================

    completion_select #(
        .num_alu   (num_alu),
        .cdb_width (cdb_width)
    ) u_completion_select (
        .clock      (clock),
        .rst_n      (rst_n),
        .mispredict (mispredict),
        .gnt        (gnt),
        .res        (res_if),
        .fu_valid   (fu_valid),
        .fu_tag     (fu_tag),
        .fu_data    (fu_data),
        .ex_valid   (ex_valid),
        .ex_rob_idx (ex_rob_idx),
        .ex_dest_pr (ex_dest_pr),
        .ex_result  (ex_result)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int period = 100
) (
    output logic clock
);

    // Free-running, starts low so the first rising edge is at half a period
    initial begin
        clock = 1'b0;
        forever begin
            #(period / 2) clock = ~clock;
        end
    end

endmodule

`default_nettype wire

// File: bench/execute_stage_assertions.sv
`default_nettype none

module execute_stage_assertions #(
    parameter int num_alu   = 3,
    parameter int cdb_width = 2
) (
    input logic                              clock,
    input logic                              rst_n,
    input logic                              mispredict,
    input logic [cdb_width-1:0][num_alu-1:0] gnt,
    input logic [num_alu-1:0]                issue_valid,
    input logic [num_alu-1:0]                fu_valid,
    input logic [cdb_width-1:0]              ex_valid
);

    // Failure tally, read by the testbench
    int fail_count = 0;

    // ========================================================================
    // Flush behavior
    // ========================================================================

    // Reset or mispredict empties every slot one edge later
    a_flush_clears: assert property (
        @(posedge clock) (!rst_n || mispredict) |=> (ex_valid == '0)
    ) else begin
        fail_count++;
        $error("ex_valid not cleared after reset or mispredict");
    end

    // ========================================================================
    // Grant behavior
    // ========================================================================

    // A live slot needs a grant in the cycle before, outside a flush
    for (genvar i = 0; i < cdb_width; i++) begin : g_slot
        a_valid_needs_grant: assert property (
            @(posedge clock) disable iff (!rst_n)
            ex_valid[i] |-> $past(rst_n && !mispredict && (|gnt[i]))
        ) else begin
            fail_count++;
            $error("ex_valid set in slot %0d without a grant in the cycle before", i);
        end
    end

    // ========================================================================
    // CDB candidate qualifier
    // ========================================================================

    // Single-cycle lanes, candidate valid tracks issue valid
    a_fu_valid_follows_issue: assert property (
        @(posedge clock) fu_valid == issue_valid
    ) else begin
        fail_count++;
        $error("fu_valid differs from issue_valid");
    end

endmodule

`default_nettype wire

// File: bench/execute_stage_tb.sv
`default_nettype none

module execute_stage_tb;

    import exec_pkg::*;

    localparam int num_alu      = 3;
    localparam int cdb_width    = 2;
    localparam int period       = 100;
    localparam int reset_cycles = 10;
    // Random ALU vectors and the bound on all vectors run
    localparam int num_random   = 60;
    localparam int num_vectors  = 80;
    localparam int watchdog_time = num_vectors * period * 2 + reset_cycles * period;

    logic clock;
    logic rst_n;

    // DUT inputs
    logic [num_alu-1:0]                 issue_valid;
    logic [num_alu-1:0][func_bits-1:0]  issue_func;
    logic [num_alu-1:0][opa_bits-1:0]   issue_opa_sel;
    logic [num_alu-1:0][opb_bits-1:0]   issue_opb_sel;
    logic [num_alu-1:0][xlen-1:0]       issue_pc;
    logic [num_alu-1:0][xlen-1:0]       issue_imm;
    logic [num_alu-1:0][preg_bits-1:0]  issue_src1_tag;
    logic [num_alu-1:0][preg_bits-1:0]  issue_src2_tag;
    logic [num_alu-1:0][preg_bits-1:0]  issue_dest_tag;
    logic [num_alu-1:0][rob_bits-1:0]   issue_rob_idx;
    logic [num_alu-1:0][xlen-1:0]       prf_rd_data1;
    logic [num_alu-1:0][xlen-1:0]       prf_rd_data2;
    logic [cdb_width-1:0]               cdb_valid;
    logic [cdb_width-1:0][preg_bits-1:0] cdb_tag;
    logic [cdb_width-1:0][xlen-1:0]     cdb_data;
    logic [cdb_width-1:0][num_alu-1:0]  gnt;
    logic                               mispredict;

    // DUT outputs
    logic [num_alu-1:0]                  prf_rd_en1;
    logic [num_alu-1:0]                  prf_rd_en2;
    logic [num_alu-1:0][preg_bits-1:0]   prf_rd_tag1;
    logic [num_alu-1:0][preg_bits-1:0]   prf_rd_tag2;
    logic [num_alu-1:0]                  fu_valid;
    logic [num_alu-1:0][preg_bits-1:0]   fu_tag;
    logic [num_alu-1:0][xlen-1:0]        fu_data;
    logic [cdb_width-1:0]                ex_valid;
    logic [cdb_width-1:0][rob_bits-1:0]  ex_rob_idx;
    logic [cdb_width-1:0][preg_bits-1:0] ex_dest_pr;
    logic [cdb_width-1:0][xlen-1:0]      ex_result;

    int          errors = 0;
    string       test_name = "none";
    int unsigned lcg_state = 22;

    tb_clock_gen #(.period(period)) u_clock_gen (.clock(clock));

    execute_stage #(.num_alu(num_alu), .cdb_width(cdb_width)) UUT (.*);

    bind execute_stage execute_stage_assertions #(
        .num_alu   (num_alu),
        .cdb_width (cdb_width)
    ) u_assert (
        .clock       (clock),
        .rst_n       (rst_n),
        .mispredict  (mispredict),
        .gnt         (gnt),
        .issue_valid (issue_valid),
        .fu_valid    (fu_valid),
        .ex_valid    (ex_valid)
    );

    // ========================================================================
    // Reference rules
    // ========================================================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // PRF contents as a fixed pattern of the whole tag
    function automatic logic [31:0] prf_value(input logic [preg_bits-1:0] tag);
        return {tag ^ 6'h2a, 2'b10, ~tag, 2'b01, tag, 2'b11, 2'b00, tag};
    endfunction

    // Same-cycle PRF answer
    always_comb begin
        for (int k = 0; k < num_alu; k++) begin
            prf_rd_data1[k] = prf_value(prf_rd_tag1[k]);
            prf_rd_data2[k] = prf_value(prf_rd_tag2[k]);
        end
    end

    // Later CDB slots take priority on a tag match
    function automatic logic [31:0] source_value(input logic [preg_bits-1:0] tag);
        logic [31:0] v;
        v = prf_value(tag);
        for (int c = 0; c < cdb_width; c++) begin
            if (cdb_valid[c] && (cdb_tag[c] == tag)) begin
                v = cdb_data[c];
            end
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_model(input logic [3:0] f, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            // Differing signs decide by sign of a alone
            alu_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            alu_sltu: return {31'b0, a < b};
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default:  return 32'h0;
        endcase
    endfunction

    // ========================================================================
    // Checking
    // ========================================================================

    task automatic expect_eq(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("ERR %s %s expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    // Outputs sampled at the falling edge one rising edge after the stimulus
    task automatic apply_and_check();
        logic [31:0]                  a;
        logic [31:0]                  b;
        logic [num_alu-1:0][31:0]     lane_res;
        int                           win;
        @(negedge clock);
        for (int k = 0; k < num_alu; k++) begin
            case (issue_opa_sel[k])
                opa_rs1: a = source_value(issue_src1_tag[k]);
                opa_npc: a = issue_pc[k] + 32'(inst_bytes);
                opa_pc:  a = issue_pc[k];
                default: a = 32'h0;
            endcase
            b = (issue_opb_sel[k] == opb_imm) ? issue_imm[k]
                                               : source_value(issue_src2_tag[k]);
            lane_res[k] = alu_model(issue_func[k], a, b);
            expect_eq($sformatf("fu_valid[%0d]", k), 32'(issue_valid[k]), 32'(fu_valid[k]));
            expect_eq($sformatf("fu_tag[%0d]", k), 32'(issue_dest_tag[k]), 32'(fu_tag[k]));
            expect_eq($sformatf("prf_rd_en1[%0d]", k), 32'(issue_valid[k]),
                      32'(prf_rd_en1[k]));
            expect_eq($sformatf("prf_rd_en2[%0d]", k),
                      32'(issue_valid[k] && (issue_opb_sel[k] == opb_rs2)),
                      32'(prf_rd_en2[k]));
            expect_eq($sformatf("prf_rd_tag1[%0d]", k),
                      issue_valid[k] ? 32'(issue_src1_tag[k]) : 32'h0, 32'(prf_rd_tag1[k]));
            expect_eq($sformatf("prf_rd_tag2[%0d]", k),
                      issue_valid[k] ? 32'(issue_src2_tag[k]) : 32'h0, 32'(prf_rd_tag2[k]));
            if (issue_valid[k]) begin
                expect_eq($sformatf("fu_data[%0d]", k), lane_res[k], fu_data[k]);
            end
        end
        for (int i = 0; i < cdb_width; i++) begin
            // Highest granted lane wins the slot
            win = -1;
            for (int k = 0; k < num_alu; k++) begin
                if (gnt[i][k]) begin
                    win = k;
                end
            end
            expect_eq($sformatf("ex_valid[%0d]", i), 32'(win >= 0 && !mispredict),
                      32'(ex_valid[i]));
            if (win >= 0 && !mispredict) begin
                expect_eq($sformatf("ex_rob_idx[%0d]", i), 32'(issue_rob_idx[win]),
                          32'(ex_rob_idx[i]));
                expect_eq($sformatf("ex_dest_pr[%0d]", i), 32'(issue_dest_tag[win]),
                          32'(ex_dest_pr[i]));
                expect_eq($sformatf("ex_result[%0d]", i), lane_res[win], ex_result[i]);
            end
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic clear_inputs();
        issue_valid    = '0;
        issue_func     = '0;
        issue_opa_sel  = '0;
        issue_opb_sel  = '0;
        issue_pc       = '0;
        issue_imm      = '0;
        issue_src1_tag = '0;
        issue_src2_tag = '0;
        issue_dest_tag = '0;
        issue_rob_idx  = '0;
        cdb_valid      = '0;
        cdb_tag        = '0;
        cdb_data       = '0;
        gnt            = '0;
        mispredict     = 1'b0;
    endtask

    // All lanes live with register operands and a quiet CDB
    task automatic randomize_lanes();
        logic [31:0] r;
        clear_inputs();
        for (int k = 0; k < num_alu; k++) begin
            r = lcg_next();
            issue_valid[k]    = 1'b1;
            issue_func[k]     = func_bits'(r[31:16] % 16'd10);
            issue_opa_sel[k]  = opa_rs1;
            issue_opb_sel[k]  = opb_rs2;
            issue_src1_tag[k] = r[15:10];
            issue_src2_tag[k] = r[9:4];
            r = lcg_next();
            issue_dest_tag[k] = r[31:26];
            issue_rob_idx[k]  = r[25:21];
            r = lcg_next();
            issue_pc[k]       = {r[31:2], 2'b00};
            issue_imm[k]      = lcg_next();
        end
    endtask

    // Grants only to live lanes
    task automatic random_grants();
        logic [31:0] r;
        r = lcg_next();
        for (int i = 0; i < cdb_width; i++) begin
            for (int k = 0; k < num_alu; k++) begin
                gnt[i][k] = r[31 - i * num_alu - k] && issue_valid[k];
            end
        end
    endtask

    initial begin
        clear_inputs();
        rst_n = 1'b0;
        // Release reset on the falling edge after the last reset cycle
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        test_name = "reset";
        apply_and_check();

        // Every function code cycles through lane 0
        test_name = "alu";
        for (int n = 0; n < num_random; n++) begin
            randomize_lanes();
            issue_func[0] = func_bits'(n % 10);
            random_grants();
            apply_and_check();
        end

        // Operand A sources and immediate operand B
        test_name = "opsel";
        randomize_lanes();
        issue_opa_sel[0] = opa_pc;
        issue_opa_sel[1] = opa_npc;
        issue_opa_sel[2] = opa_zero;
        issue_opb_sel[1] = opb_imm;
        apply_and_check();
        randomize_lanes();
        issue_opb_sel = {num_alu{opb_imm}};
        apply_and_check();
        test_name = "invalid";
        randomize_lanes();
        issue_valid[2] = 1'b0;
        apply_and_check();

        // Forwarding with a single match, a double match and an idle slot
        test_name = "cdb";
        randomize_lanes();
        cdb_valid    = 2'b01;
        cdb_tag[0]   = issue_src1_tag[0];
        cdb_data[0]  = lcg_next();
        apply_and_check();
        randomize_lanes();
        cdb_valid    = 2'b11;
        cdb_tag[0]   = issue_src2_tag[1];
        cdb_tag[1]   = issue_src2_tag[1];
        cdb_data[0]  = lcg_next();
        cdb_data[1]  = lcg_next();
        apply_and_check();
        randomize_lanes();
        cdb_valid    = 2'b10;
        cdb_tag[0]   = issue_src1_tag[2];
        cdb_tag[1]   = ~issue_src1_tag[2];
        cdb_data[0]  = lcg_next();
        cdb_data[1]  = lcg_next();
        apply_and_check();

        // Directed grants with two lanes on one slot
        test_name = "grant";
        randomize_lanes();
        gnt[0] = 3'b100;
        gnt[1] = 3'b001;
        apply_and_check();
        randomize_lanes();
        gnt[1] = 3'b010;
        apply_and_check();
        randomize_lanes();
        gnt[0] = 3'b011;
        gnt[1] = 3'b110;
        apply_and_check();

        // Mispredict while both slots are granted
        test_name = "flush";
        randomize_lanes();
        gnt[0] = 3'b001;
        gnt[1] = 3'b100;
        mispredict = 1'b1;
        apply_and_check();
        randomize_lanes();
        gnt[0] = 3'b010;
        gnt[1] = 3'b001;
        apply_and_check();
        randomize_lanes();
        apply_and_check();

        $display("Summary: %0d check errors, %0d assertion errors",
                 errors, UUT.u_assert.fail_count);
        if (errors == 0 && UUT.u_assert.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_time);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/exec_pkg.sv
design/alu_op_if.sv
design/alu_result_if.sv
design/operand_resolve.sv
design/alu_lane.sv
design/completion_select.sv
design/execute_stage.sv
bench/tb_clock_gen.sv
bench/execute_stage_assertions.sv
bench/execute_stage_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execute_stage_tb
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Verification failed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FLIST) $(VFLAGS)

run: compile
	@$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
